/* verilog/stream_pkg.sv */
// Widths and types of the ingest datapath: words, samples, bytes and frame counts
// Referenced by scoped name from the arbiter, FIFO, unpacker and top level
`default_nettype none

package stream_pkg;

    //======================================================================
    // Widths
    //======================================================================

    // Buffered word, same width as the PCIe user stream
    localparam int word_width = 64;
    // One image sample
    localparam int sample_width = 16;
    // Samples packed in each buffered word
    localparam int samples_per_word = word_width / sample_width;
    // Ethernet and UART user data
    localparam int byte_width = 8;
    // Completed frame counter
    localparam int frame_count_width = 16;

    //======================================================================
    // Types
    //======================================================================

    typedef logic [word_width-1:0] word_t;
    typedef logic [sample_width-1:0] sample_t;
    typedef logic [byte_width-1:0] byte_t;
    typedef logic [frame_count_width-1:0] frame_count_t;

endpackage

`default_nettype wire

/* verilog/control_pkg.sv */
// Control encodings for the ingest path
// Holds the source selection used by the arbiter and the top-level port width
`default_nettype none

package control_pkg;

    //======================================================================
    // Source selection
    //======================================================================

    // Bits needed to encode a source choice
    localparam int source_sel_width = 2;

    // Fixed sources first, automatic priority last
    typedef enum logic [source_sel_width-1:0] {
        src_pcie = 2'd0,
        src_eth  = 2'd1,
        src_uart = 2'd2,
        // PCIe, then Ethernet, then UART
        src_auto = 2'd3
    } source_sel_e;

endpackage

`default_nettype wire

/* verilog/reset_synchronizer.sv */
// Conditions the external reset for the clk domain
// Assertion is immediate, release is synchronous after five edges
`default_nettype none

module reset_synchronizer (
    input  wire  clk,
    input  wire  ext_reset_n,
    output logic rst_n
);

    // Four flop release chain
    logic [3:0] sync_q;

    // Async clear on ext_reset_n, shift ones in once it is high
    always_ff @(posedge clk or negedge ext_reset_n) begin
        if (!ext_reset_n) begin
            sync_q <= 4'b0000;
            rst_n  <= 1'b0;
        end else begin
            sync_q <= {sync_q[2:0], 1'b1};
            // Output register adds the fifth edge
            rst_n  <= sync_q[3];
        end
    end

endmodule

`default_nettype wire

/* verilog/source_arbiter.sv */
// Picks one of the PCIe, Ethernet or UART sources and presents it as a word stream
// Fixed selection or automatic priority, purely combinational
`default_nettype none

module source_arbiter (
    input  wire control_pkg::source_sel_e source_sel,

    // PCIe word source
    input  wire stream_pkg::word_t        pcie_data,
    input  wire                           pcie_valid,
    output logic                          pcie_ready,

    // Ethernet byte source
    input  wire stream_pkg::byte_t        eth_data,
    input  wire                           eth_valid,
    output logic                          eth_ready,

    // UART byte source
    input  wire stream_pkg::byte_t        uart_data,
    input  wire                           uart_valid,
    output logic                          uart_ready,

    // Word stream to the FIFO
    output stream_pkg::word_t             word,
    output logic                          word_valid,
    input  wire                           word_ready
);

    localparam int pad_width = stream_pkg::word_width - stream_pkg::byte_width;

    // Byte sources zero extended, byte in the low bits
    stream_pkg::word_t eth_word;
    stream_pkg::word_t uart_word;

    assign eth_word  = {{pad_width{1'b0}}, eth_data};
    assign uart_word = {{pad_width{1'b0}}, uart_data};

    //======================================================================
    // Selection
    //======================================================================

    always_comb begin
        // Losers never see ready
        pcie_ready = 1'b0;
        eth_ready  = 1'b0;
        uart_ready = 1'b0;
        word       = pcie_data;
        word_valid = 1'b0;

        case (source_sel)
            control_pkg::src_pcie: begin
                word       = pcie_data;
                word_valid = pcie_valid;
                pcie_ready = word_ready;
            end
            control_pkg::src_eth: begin
                word       = eth_word;
                word_valid = eth_valid;
                eth_ready  = word_ready;
            end
            control_pkg::src_uart: begin
                word       = uart_word;
                word_valid = uart_valid;
                uart_ready = word_ready;
            end
            default: begin
                // Auto mode, winner picked fresh every cycle
                if (pcie_valid) begin
                    word       = pcie_data;
                    word_valid = 1'b1;
                    pcie_ready = word_ready;
                end else if (eth_valid) begin
                    word       = eth_word;
                    word_valid = 1'b1;
                    eth_ready  = word_ready;
                end else begin
                    // UART last, also the idle default
                    word       = uart_word;
                    word_valid = uart_valid;
                    uart_ready = word_ready;
                end
            end
        endcase
    end

endmodule

`default_nettype wire

/* verilog/word_fifo.sv */
// Word buffer between the source arbiter and the sample unpacker
// Circular storage with valid/ready on both sides, FIFO_DEPTH a power of two
`default_nettype none

module word_fifo #(
    parameter int FIFO_DEPTH = 16
) (
    input  wire               clk,
    input  wire               rst_n,

    // Write side
    input  wire stream_pkg::word_t in_word,
    input  wire               in_valid,
    output logic              in_ready,

    // Read side
    output stream_pkg::word_t out_word,
    output logic              out_valid,
    input  wire               out_ready
);

    localparam int addr_width = $clog2(FIFO_DEPTH);

    //======================================================================
    // Storage and pointers
    //======================================================================

    // Extra top bit tells full from empty
    logic [addr_width:0] wr_ptr;
    logic [addr_width:0] rd_ptr;

    stream_pkg::word_t mem [FIFO_DEPTH];

    logic full;
    logic empty;
    logic do_write;
    logic do_read;

    // Same address, different lap means full
    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[addr_width] != rd_ptr[addr_width]) &&
                   (wr_ptr[addr_width-1:0] == rd_ptr[addr_width-1:0]);

    // Handshakes
    assign in_ready  = !full;
    assign out_valid = !empty;
    assign do_write  = in_valid && in_ready;
    assign do_read   = out_valid && out_ready;

    // Head of queue read straight from the array
    assign out_word = mem[rd_ptr[addr_width-1:0]];

    //======================================================================
    // Update
    //======================================================================

    // Array write
    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[wr_ptr[addr_width-1:0]] <= in_word;
        end
    end

    // Pointer advance, each side on its own handshake
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/sample_unpacker.sv */
// Splits buffered words into image samples, low-order sample first
// Marks frame start and end, drops word leftovers at frame end, counts frames
`default_nettype none

module sample_unpacker #(
    parameter int FRAME_SAMPLES = 150528
) (
    input  wire                      clk,
    input  wire                      rst_n,

    // Words from the FIFO
    input  wire stream_pkg::word_t   in_word,
    input  wire                      in_valid,
    output logic                     in_ready,

    // Sample stream
    output stream_pkg::sample_t      image_data,
    output logic                     image_valid,
    input  wire                      image_ready,
    output logic                     frame_start,
    output logic                     frame_end,

    // Frame counter
    output stream_pkg::frame_count_t frame_count,
    input  wire                      clear_counters
);

    localparam int lane_width = $clog2(stream_pkg::samples_per_word);
    localparam int pos_width  = (FRAME_SAMPLES > 1) ? $clog2(FRAME_SAMPLES) : 1;
    localparam logic [lane_width-1:0] last_lane = lane_width'(stream_pkg::samples_per_word - 1);
    localparam logic [pos_width-1:0]  last_pos  = pos_width'(FRAME_SAMPLES - 1);

    //======================================================================
    // Held word and position
    //======================================================================

    // Word being unpacked
    stream_pkg::word_t word_q;
    // Current sample within the word
    logic [lane_width-1:0] lane_q;
    // Current sample within the frame
    logic [pos_width-1:0] frame_pos_q;

    logic sample_fire;
    logic last_in_word;
    logic take_word;

    // Current lane to the output
    assign image_data = word_q[lane_q*stream_pkg::sample_width +: stream_pkg::sample_width];

    // Markers follow the frame position
    assign frame_start = image_valid && (frame_pos_q == '0);
    assign frame_end   = image_valid && (frame_pos_q == last_pos);

    assign sample_fire = image_valid && image_ready;

    // Word is done at its top lane or at frame end
    assign last_in_word = (lane_q == last_lane) || (frame_pos_q == last_pos);

    // Refill when idle or as the last pending sample leaves
    assign in_ready  = !image_valid || (image_ready && last_in_word);
    assign take_word = in_valid && in_ready;

    //======================================================================
    // Control
    //======================================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            image_valid <= 1'b0;
            lane_q      <= '0;
        end else if (take_word) begin
            // Fresh word, start at lane 0
            image_valid <= 1'b1;
            lane_q      <= '0;
        end else if (sample_fire) begin
            if (last_in_word) begin
                // Leftover lanes after frame end are dropped here
                image_valid <= 1'b0;
            end else begin
                lane_q <= lane_q + 1'b1;
            end
        end
    end

    // Payload capture
    always_ff @(posedge clk) begin
        if (take_word) begin
            word_q <= in_word;
        end
    end

    // Frame position, wraps on the frame_end transfer
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            frame_pos_q <= '0;
        end else if (sample_fire) begin
            if (frame_pos_q == last_pos) begin
                frame_pos_q <= '0;
            end else begin
                frame_pos_q <= frame_pos_q + 1'b1;
            end
        end
    end

    //======================================================================
    // Frame counter
    //======================================================================

    // Clear wins over a coincident frame end
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            frame_count <= '0;
        end else if (clear_counters) begin
            frame_count <= '0;
        end else if (sample_fire && frame_end) begin
            frame_count <= frame_count + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* verilog/frame_ingest_top.sv */
// Top level of the image ingest path: reset, source arbiter, word FIFO, unpacker
// Sets FIFO_DEPTH and FRAME_SAMPLES and passes them down
`default_nettype none

module frame_ingest_top #(
    parameter int FIFO_DEPTH    = 16,
    // 224 x 224 x 3 samples
    parameter int FRAME_SAMPLES = 150528
) (
    input  wire                                    clk,
    input  wire                                    ext_reset_n,

    // PCIe user stream
    input  wire stream_pkg::word_t                 pcie_data,
    input  wire                                    pcie_valid,
    output wire                                    pcie_ready,

    // Ethernet user stream
    input  wire stream_pkg::byte_t                 eth_data,
    input  wire                                    eth_valid,
    output wire                                    eth_ready,

    // UART user stream
    input  wire stream_pkg::byte_t                 uart_data,
    input  wire                                    uart_valid,
    output wire                                    uart_ready,

    // Source choice, decoded as source_sel_e
    input  wire [control_pkg::source_sel_width-1:0] source_sel,

    // Image sample stream
    output wire stream_pkg::sample_t               image_data,
    output wire                                    image_valid,
    input  wire                                    image_ready,
    output wire                                    frame_start,
    output wire                                    frame_end,

    // Frame statistics
    output wire stream_pkg::frame_count_t          frame_count,
    input  wire                                    clear_counters
);

    //======================================================================
    // Internal links
    //======================================================================

    // Conditioned reset
    wire rst_n;

    // Arbiter to FIFO
    wire stream_pkg::word_t arb_word;
    wire                    arb_valid;
    wire                    arb_ready;

    // FIFO to unpacker
    wire stream_pkg::word_t buf_word;
    wire                    buf_valid;
    wire                    buf_ready;

    //======================================================================
    // Instances
    //======================================================================

    reset_synchronizer u_reset_synchronizer (
        .clk         (clk),
        .ext_reset_n (ext_reset_n),
        .rst_n       (rst_n)
    );

    source_arbiter u_source_arbiter (
        .source_sel (control_pkg::source_sel_e'(source_sel)),
        .pcie_data  (pcie_data),
        .pcie_valid (pcie_valid),
        .pcie_ready (pcie_ready),
        .eth_data   (eth_data),
        .eth_valid  (eth_valid),
        .eth_ready  (eth_ready),
        .uart_data  (uart_data),
        .uart_valid (uart_valid),
        .uart_ready (uart_ready),
        .word       (arb_word),
        .word_valid (arb_valid),
        .word_ready (arb_ready)
    );

    word_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_word_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_word   (arb_word),
        .in_valid  (arb_valid),
        .in_ready  (arb_ready),
        .out_word  (buf_word),
        .out_valid (buf_valid),
        .out_ready (buf_ready)
    );

    sample_unpacker #(
        .FRAME_SAMPLES (FRAME_SAMPLES)
    ) u_sample_unpacker (
        .clk            (clk),
        .rst_n          (rst_n),
        .in_word        (buf_word),
        .in_valid       (buf_valid),
        .in_ready       (buf_ready),
        .image_data     (image_data),
        .image_valid    (image_valid),
        .image_ready    (image_ready),
        .frame_start    (frame_start),
        .frame_end      (frame_end),
        .frame_count    (frame_count),
        .clear_counters (clear_counters)
    );

endmodule

`default_nettype wire

/* tests/tb_frame_ingest.sv */
// Directed testbench for the frame ingest path
// Drives the three sources, predicts the sample stream and checks markers and frame counts
`default_nettype none

module tb_frame_ingest;

    localparam int frame_samples = 10;
    localparam int fifo_depth    = 16;
    // Reset 21, fixed and auto tests about 150, back-pressure about 450, frames about 100
    localparam int test_cycles    = 750;
    localparam int timeout_cycles = 4 * test_cycles;
    // Sink behaviour
    localparam int sink_open   = 0;
    localparam int sink_hold   = 1;
    localparam int sink_random = 2;

    logic clk;
    logic ext_reset_n;
    stream_pkg::word_t pcie_data;
    logic pcie_valid;
    wire pcie_ready;
    stream_pkg::byte_t eth_data;
    logic eth_valid;
    wire eth_ready;
    stream_pkg::byte_t uart_data;
    logic uart_valid;
    wire uart_ready;
    logic [control_pkg::source_sel_width-1:0] source_sel;
    wire stream_pkg::sample_t image_data;
    wire image_valid;
    logic image_ready;
    wire frame_start;
    wire frame_end;
    wire stream_pkg::frame_count_t frame_count;
    logic clear_counters;

    //======================================================================
    // Model state and bookkeeping
    //======================================================================

    // Predicted samples as {start, end, data}
    logic [17:0] exp_q[$];
    // Source of each accepted word, 0 PCIe, 1 Ethernet, 2 UART
    int src_log[$];
    int model_pos = 0;
    int exp_count = 0;
    int checks = 0;
    int errors = 0;
    int cycle_count = 0;
    int sink_mode = sink_open;
    bit pcie_stalled = 1'b0;
    integer seed = 32'h89a9f646;

    frame_ingest_top #(
        .FIFO_DEPTH    (fifo_depth),
        .FRAME_SAMPLES (frame_samples)
    ) dut (
        .clk            (clk),
        .ext_reset_n    (ext_reset_n),
        .pcie_data      (pcie_data),
        .pcie_valid     (pcie_valid),
        .pcie_ready     (pcie_ready),
        .eth_data       (eth_data),
        .eth_valid      (eth_valid),
        .eth_ready      (eth_ready),
        .uart_data      (uart_data),
        .uart_valid     (uart_valid),
        .uart_ready     (uart_ready),
        .source_sel     (source_sel),
        .image_data     (image_data),
        .image_valid    (image_valid),
        .image_ready    (image_ready),
        .frame_start    (frame_start),
        .frame_end      (frame_end),
        .frame_count    (frame_count),
        .clear_counters (clear_counters)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Sink ready, changed 2 units after the edge
    always @(posedge clk) begin
        #2;
        case (sink_mode)
            sink_hold: image_ready = 1'b0;
            sink_random: image_ready = (($random(seed) & 1) != 0);
            default: image_ready = 1'b1;
        endcase
    end

    // Run limit
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= timeout_cycles) begin
            $display("Timeout: run stopped after %0d cycles", cycle_count);
            $display("Checks run: %0d, errors: %0d", checks, errors);
            $display("Checks failed");
            $finish;
        end
    end

    //======================================================================
    // Reference model
    //======================================================================

    // Low sample first, rest of the word dropped after a frame end
    function automatic void push_word(stream_pkg::word_t w);
        logic is_start;
        logic is_end;
        for (int lane = 0; lane < stream_pkg::samples_per_word; lane++) begin
            is_start = (model_pos == 0);
            is_end   = (model_pos == frame_samples - 1);
            exp_q.push_back({is_start, is_end,
                             w[lane*stream_pkg::sample_width +: stream_pkg::sample_width]});
            if (is_end) begin
                model_pos = 0;
                break;
            end
            model_pos++;
        end
    endfunction

    // Source allowed to see ready this cycle
    function automatic int expected_winner();
        int result;
        case (source_sel)
            control_pkg::src_pcie: result = 0;
            control_pkg::src_eth: result = 1;
            control_pkg::src_uart: result = 2;
            default: result = pcie_valid ? 0 : (eth_valid ? 1 : 2);
        endcase
        return result;
    endfunction

    task automatic report_mismatch(string name, logic [63:0] got, logic [63:0] want);
        errors++;
        $display("Mismatch at %0t: %s got %0h expected %0h", $time, name, got, want);
    endtask

    //======================================================================
    // Monitor, sampled mid-cycle where everything is stable
    //======================================================================

    always @(negedge clk) begin : monitor
        logic [17:0] expected;
        int win;
        logic xfer_end;
        xfer_end = 1'b0;
        // Accepted words feed the model in arrival order
        if (pcie_valid && pcie_ready) begin
            push_word(pcie_data);
            src_log.push_back(0);
        end
        if (eth_valid && eth_ready) begin
            push_word(stream_pkg::word_t'(eth_data));
            src_log.push_back(1);
        end
        if (uart_valid && uart_ready) begin
            push_word(stream_pkg::word_t'(uart_data));
            src_log.push_back(2);
        end
        if (pcie_valid && !pcie_ready) begin
            pcie_stalled = 1'b1;
        end
        // Only the winner may see ready
        win = expected_winner();
        checks++;
        assert (!(pcie_ready && win != 0) && !(eth_ready && win != 1) &&
                !(uart_ready && win != 2)) else begin
            errors++;
            $display("Ready given to a source that lost arbitration at %0t", $time);
        end
        checks++;
        assert (frame_count == exp_count) else
            report_mismatch("frame_count", frame_count, exp_count);
        if (image_valid && image_ready) begin
            checks++;
            assert (exp_q.size() != 0) else begin
                errors++;
                $display("Sample %h at %0t arrived with none predicted", image_data, $time);
            end
            if (exp_q.size() != 0) begin
                expected = exp_q.pop_front();
                xfer_end = expected[16];
                checks++;
                assert (image_data == expected[15:0]) else
                    report_mismatch("image_data", image_data, expected[15:0]);
                checks++;
                assert (frame_start == expected[17]) else
                    report_mismatch("frame_start", frame_start, expected[17]);
                checks++;
                assert (frame_end == expected[16]) else
                    report_mismatch("frame_end", frame_end, expected[16]);
            end
        end
        // Counter moves on the coming edge
        if (clear_counters) begin
            exp_count = 0;
        end else if (xfer_end) begin
            exp_count++;
        end
    end

    //======================================================================
    // Drivers
    //======================================================================

    task automatic send_pcie(stream_pkg::word_t w);
        pcie_data  = w;
        pcie_valid = 1'b1;
        @(negedge clk);
        while (!pcie_ready) @(negedge clk);
        @(posedge clk);
        #2;
        pcie_valid = 1'b0;
    endtask

    task automatic send_eth(stream_pkg::byte_t b);
        eth_data  = b;
        eth_valid = 1'b1;
        @(negedge clk);
        while (!eth_ready) @(negedge clk);
        @(posedge clk);
        #2;
        eth_valid = 1'b0;
    endtask

    task automatic send_uart(stream_pkg::byte_t b);
        uart_data  = b;
        uart_valid = 1'b1;
        @(negedge clk);
        while (!uart_ready) @(negedge clk);
        @(posedge clk);
        #2;
        uart_valid = 1'b0;
    endtask

    // Wait until every predicted sample has left
    task automatic wait_drain();
        @(posedge clk);
        while (exp_q.size() != 0) @(posedge clk);
        #2;
    endtask

    //======================================================================
    // Tests
    //======================================================================

    task automatic test_fixed_pcie();
        source_sel = control_pkg::src_pcie;
        // Byte sources valid but ignored
        eth_data   = 8'h5a;
        eth_valid  = 1'b1;
        uart_data  = 8'ha5;
        uart_valid = 1'b1;
        for (int i = 0; i < 6; i++) begin
            send_pcie({$random(seed), $random(seed)});
        end
        eth_valid  = 1'b0;
        uart_valid = 1'b0;
        wait_drain();
    endtask

    task automatic test_fixed_bytes();
        source_sel = control_pkg::src_eth;
        for (int i = 0; i < 4; i++) begin
            send_eth(8'($random(seed)));
        end
        source_sel = control_pkg::src_uart;
        for (int i = 0; i < 4; i++) begin
            send_uart(8'($random(seed)));
        end
        wait_drain();
    endtask

    task automatic test_auto_priority();
        src_log.delete();
        source_sel = control_pkg::src_auto;
        fork
            send_pcie(64'h0123_4567_89ab_cdef);
            send_eth(8'h3c);
            send_uart(8'hc3);
        join
        fork
            send_eth(8'h11);
            send_uart(8'h22);
        join
        wait_drain();
        checks++;
        assert (src_log.size() == 5 && src_log[0] == 0 && src_log[1] == 1 &&
                src_log[2] == 2 && src_log[3] == 1 && src_log[4] == 2) else begin
            errors++;
            $display("Automatic priority took the sources in the wrong order");
        end
    endtask

    task automatic test_back_pressure();
        stream_pkg::word_t words[fifo_depth+8];
        foreach (words[i]) begin
            words[i] = {$random(seed), $random(seed)};
        end
        source_sel   = control_pkg::src_pcie;
        pcie_stalled = 1'b0;
        sink_mode    = sink_hold;
        fork
            foreach (words[i]) begin
                send_pcie(words[i]);
            end
            begin
                // FIFO and unpacker fill, then release the sink at random
                @(posedge clk);
                // Bounded wait for the source to stall
                for (int n = 0; n < 4 * fifo_depth && !pcie_stalled; n++) begin
                    @(posedge clk);
                end
                repeat (4) @(posedge clk);
                sink_mode = sink_random;
            end
        join
        wait_drain();
        sink_mode = sink_open;
        checks++;
        assert (pcie_stalled) else begin
            errors++;
            $display("pcie_ready never dropped while the sink was held");
        end
    endtask

    task automatic test_frames();
        source_sel = control_pkg::src_pcie;
        for (int i = 0; i < 9; i++) begin
            send_pcie({$random(seed), $random(seed)});
        end
        wait_drain();
        checks++;
        assert (frame_count != 0) else begin
            errors++;
            $display("Frame counter stayed at zero after complete frames");
        end
        clear_counters = 1'b1;
        @(posedge clk);
        #2;
        clear_counters = 1'b0;
        @(negedge clk);
        checks++;
        assert (frame_count == 0) else report_mismatch("frame_count", frame_count, 0);
    endtask

    initial begin
        ext_reset_n    = 1'b0;
        pcie_data      = '0;
        pcie_valid     = 1'b0;
        eth_data       = '0;
        eth_valid      = 1'b0;
        uart_data      = '0;
        uart_valid     = 1'b0;
        source_sel     = control_pkg::src_pcie;
        image_ready    = 1'b0;
        clear_counters = 1'b0;
        repeat (16) @(posedge clk);
        #2;
        ext_reset_n = 1'b1;
        // Internal reset lets go five edges later
        repeat (5) @(posedge clk);
        #2;
        test_fixed_pcie();
        test_fixed_bytes();
        test_auto_priority();
        test_back_pressure();
        test_frames();
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
verilog/stream_pkg.sv
verilog/control_pkg.sv
verilog/reset_synchronizer.sv
verilog/source_arbiter.sv
verilog/word_fifo.sv
verilog/sample_unpacker.sv
verilog/frame_ingest_top.sv
tests/tb_frame_ingest.sv

/* Bender.yml */
package:
  name: frame_ingest

sources:
  - verilog/stream_pkg.sv
  - verilog/control_pkg.sv
  - verilog/reset_synchronizer.sv
  - verilog/source_arbiter.sv
  - verilog/word_fifo.sv
  - verilog/sample_unpacker.sv
  - verilog/frame_ingest_top.sv
  - target: test
    files:
      - tests/tb_frame_ingest.sv
